// File: aguPipe.f
+incdir+design
design/aguPipePkg.sv
design/aguRegFile.sv
design/aguIssueStage.sv
design/aguAddrGen.sv
design/aguAccessCheck.sv
design/aguPipe.sv
tests/aguPipeChecker.sv
tests/aguPipeTb.sv

// File: runSim.sh
#!/bin/sh
# build and run with Verilator; the run fails if the log holds the fail line
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f aguPipe.f --top-module aguPipeTb -o aguPipeSim \
	&& ./obj_dir/aguPipeSim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
! grep -q "Result: FAILED" sim.log \
	&& grep -q "Result: PASSED" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: tests/aguPipeTb.sv
/* Testbench for the address pipeline. Inputs change on the falling edge;
   random stimulus comes from a 32-bit Galois LFSR seeded with 2. */
`timescale 1ns/10ps
`default_nettype none

`include "aguPipe_cfg.svh"

module aguPipeTb;

	import aguPipePkg::*;

	logic clk;
	logic rst;
	logic issueValid;
	aguUop_t uop;
	logic wide;
	logic wrEn;
	logic [`AGU_REG_IDX_W-1:0] wrIdx;
	logic [`AGU_ADDR_W-1:0] wrData;
	logic outValid;
	logic [`AGU_ADDR_W-1:0] outAddr;
	fault_t outFault;
	logic [3:0] testId;
	int mismatchCount;
	int protocolCount;
	int pendingCount;
	int timeoutCount;
	logic [31:0] lfsrState;

	aguPipe aguPipe_inst (.clk(clk), .rst(rst), .issueValid(issueValid), .uop(uop), .wide(wide),
		.wrEn(wrEn), .wrIdx(wrIdx), .wrData(wrData), .outValid(outValid), .outAddr(outAddr),
		.outFault(outFault));

	aguPipeChecker aguPipeChecker_inst (.clk(clk), .rst(rst), .testId(testId),
		.issueValid(issueValid), .uop(uop), .wide(wide), .wrEn(wrEn), .wrIdx(wrIdx),
		.wrData(wrData), .outValid(outValid), .outAddr(outAddr), .outFault(outFault),
		.mismatchCount(mismatchCount), .protocolCount(protocolCount),
		.pendingCount(pendingCount));

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one LFSR step per bit
	function automatic logic [47:0] randBits(input int n);
		logic [47:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[46:0], lfsrState[0]};
		end
		return v;
	endfunction

	task automatic writeReg(input logic [3:0] idx, input logic [47:0] data);
		@(negedge clk);
		issueValid = 1'b0;
		wrEn = 1'b1;
		wrIdx = idx;
		wrData = data;
	endtask

	// condition code left at zero, it is never decoded
	task automatic issueOp(input logic [3:0] test, input logic [3:0] rm, input logic [3:0] ri,
		input logic [15:0] disp, input logic [1:0] size, input logic [1:0] scale,
		input logic zext, input logic dispEn, input logic wideIn);
		@(negedge clk);
		wrEn = 1'b0;
		testId = test;
		issueValid = 1'b1;
		uop.rm = rm;
		uop.ri = ri;
		uop.disp = disp;
		uop.ctrl = {1'b0, 2'b00, size, dispEn, zext, scale};
		wide = wideIn;
	endtask

	// drop the strobes, then wait for the pipeline to empty
	task automatic drain();
		int waited;
		@(negedge clk);
		issueValid = 1'b0;
		wrEn = 1'b0;
		waited = 0;
		while (pendingCount != 0 && waited < 20)
		begin
			@(negedge clk);
			waited++;
		end
		if (pendingCount != 0)
		begin
			$display("timeout: %0d results never came out of the pipeline", pendingCount);
			timeoutCount++;
		end
	endtask

	initial
	begin
		logic [47:0] r;
		rst = 1'b1;
		issueValid = 1'b0;
		uop = '0;
		wide = 1'b1;
		wrEn = 1'b0;
		wrIdx = '0;
		wrData = '0;
		testId = 4'd0;
		timeoutCount = 0;
		lfsrState = 32'd2;
		repeat (2) @(negedge clk);
		rst = 1'b0;

		// all four scales, base r1, index r2
		writeReg(4'd1, 48'h0000_1234_5000);
		writeReg(4'd2, 48'h0000_0000_0100);
		for (int s = 0; s < 4; s++)
			issueOp(4'd1, 4'd1, 4'd2, 16'h0, 2'd0, 2'(s), 1'b0, 1'b0, 1'b1);
		drain();

		// bit 31 set, junk above it
		writeReg(4'd3, 48'hABCD_8000_0010);
		issueOp(4'd2, 4'd1, 4'd3, 16'h0, 2'd0, 2'd0, 1'b0, 1'b0, 1'b1);
		issueOp(4'd2, 4'd1, 4'd3, 16'h0, 2'd0, 2'd1, 1'b1, 1'b0, 1'b1);
		drain();

		// low carry of 1, then 2 rippling through the middle into the high segment
		writeReg(4'd4, 48'h0000_FFFE_FFFF);
		writeReg(4'd5, 48'h0000_0000_FFFF);
		issueOp(4'd3, 4'd4, 4'd5, 16'hFFFF, 2'd0, 2'd0, 1'b0, 1'b0, 1'b1);
		issueOp(4'd3, 4'd4, 4'd5, 16'hFFFF, 2'd0, 2'd0, 1'b0, 1'b1, 1'b1);
		issueOp(4'd3, 4'd4, 4'd5, 16'hFFFF, 2'd0, 2'd3, 1'b1, 1'b1, 1'b1);
		drain();

		// narrow mode
		issueOp(4'd4, 4'd4, 4'd5, 16'hFFFF, 2'd0, 2'd0, 1'b0, 1'b1, 1'b0);
		issueOp(4'd4, 4'd1, 4'd3, 16'h0, 2'd0, 2'd0, 1'b0, 1'b0, 1'b0);
		drain();

		// odd base plus disp, index r0 still zero
		writeReg(4'd8, 48'h0000_0000_1001);
		issueOp(4'd5, 4'd8, 4'd0, 16'h0, 2'd1, 2'd0, 1'b0, 1'b0, 1'b1);
		issueOp(4'd5, 4'd8, 4'd0, 16'h1, 2'd2, 2'd0, 1'b0, 1'b1, 1'b1);
		issueOp(4'd5, 4'd8, 4'd0, 16'h3, 2'd3, 2'd0, 1'b0, 1'b1, 1'b1);
		issueOp(4'd5, 4'd8, 4'd0, 16'h7, 2'd3, 2'd0, 1'b0, 1'b1, 1'b1);
		issueOp(4'd5, 4'd8, 4'd0, 16'h0, 2'd0, 2'd0, 1'b0, 1'b0, 1'b1);
		// above the limit and odd
		issueOp(4'd5, 4'd4, 4'd5, 16'hFFFF, 2'd3, 2'd0, 1'b0, 1'b1, 1'b1);
		drain();

		// random fill, then one issue per cycle with random writes alongside
		for (int i = 0; i < `AGU_REG_CNT; i++)
			writeReg(4'(i), randBits(48));
		for (int n = 0; n < 200; n++)
		begin
			@(negedge clk);
			testId = 4'd6;
			issueValid = 1'b1;
			r = randBits(4);
			uop.rm = r[3:0];
			r = randBits(4);
			uop.ri = r[3:0];
			r = randBits(16);
			uop.disp = r[15:0];
			r = randBits(9);
			uop.ctrl = r[8:0];
			r = randBits(1);
			wide = r[0];
			r = randBits(1);
			wrEn = r[0];
			r = randBits(4);
			wrIdx = r[3:0];
			wrData = randBits(48);
		end
		drain();

		$display("errors: %0d mismatches, %0d protocol, %0d timeouts, %0d still pending",
			mismatchCount, protocolCount, timeoutCount, pendingCount);
		if (mismatchCount + protocolCount + timeoutCount + pendingCount == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/aguPipeChecker.sv
/* Scoreboard for the address pipeline. Expects exactly one output per
   issue, in order, three cycles after the issue edge. */
`timescale 1ns/10ps
`default_nettype none

`include "aguPipe_cfg.svh"

module aguPipeChecker (
	input wire logic clk,
	input wire logic rst,
	input wire logic [3:0] testId,
	input wire logic issueValid,
	input aguPipePkg::aguUop_t uop,
	input wire logic wide,
	input wire logic wrEn,
	input wire logic [`AGU_REG_IDX_W-1:0] wrIdx,
	input wire logic [`AGU_ADDR_W-1:0] wrData,
	input wire logic outValid,
	input wire logic [`AGU_ADDR_W-1:0] outAddr,
	input aguPipePkg::fault_t outFault,
	output int mismatchCount,
	output int protocolCount,
	output int pendingCount
);

	import aguPipePkg::*;

	// one expected result per issue
	typedef struct packed {
		logic [`AGU_ADDR_W-1:0] addr;
		fault_t fault;
		logic [3:0] testId;
		int issueCycle;
	} expected_t;

	expected_t expQ[$];
	expected_t head;
	expected_t next;
	logic [`AGU_ADDR_W-1:0] shadow [`AGU_REG_CNT];
	int cycle;

	function automatic string testName(input logic [3:0] id);
		case (id)
			4'd1: return "scaledIndex";
			4'd2: return "extension";
			4'd3: return "dispCarry";
			4'd4: return "narrowMode";
			4'd5: return "faults";
			default: return "throughput";
		endcase
	endfunction

	// plain 48-bit sum, then narrow mode, then limit ahead of alignment
	function automatic expected_t refModel(input logic [47:0] base, input logic [47:0] index,
		input aguUop_t u, input logic wideIn);
		expected_t e;
		logic [47:0] idx;
		logic [47:0] mask;
		idx = u.ctrl[2] ? {16'h0, index[31:0]} : {{16{index[31]}}, index[31:0]};
		e.addr = base + (idx << u.ctrl[1:0]) + (u.ctrl[3] ? {32'h0, u.disp} : 48'h0);
		if (!wideIn)
			e.addr[47:32] = 16'h0;
		// low log2(size) bits
		mask = (48'h1 << u.ctrl[5:4]) - 48'h1;
		if (e.addr > `AGU_LIMIT)
			e.fault = FAULT_LIMIT;
		else if ((e.addr & mask) != '0)
			e.fault = FAULT_ALIGN;
		else
			e.fault = FAULT_NONE;
		e.testId = 4'd0;
		e.issueCycle = 0;
		return e;
	endfunction

	always @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `AGU_REG_CNT; i++)
				shadow[i] = '0;
			expQ.delete();
			cycle = 0;
			mismatchCount = 0;
			protocolCount = 0;
		end
		else
		begin
			cycle++;
			// outputs seen here were registered on the previous edge
			if (outValid && expQ.size() == 0)
			begin
				$display("outValid was high at cycle %0d with no micro-op in flight", cycle);
				protocolCount++;
			end
			else if (outValid)
			begin
				head = expQ.pop_front();
				if (outAddr !== head.addr)
				begin
					$display("ERROR %s outAddr: expected %h actual %h",
						testName(head.testId), head.addr, outAddr);
					mismatchCount++;
				end
				if (outFault !== head.fault)
				begin
					$display("ERROR %s outFault: expected %0d actual %0d",
						testName(head.testId), head.fault, outFault);
					mismatchCount++;
				end
				if (cycle - head.issueCycle != 3)
				begin
					$display("ERROR %s latency: expected 3 actual %0d",
						testName(head.testId), cycle - head.issueCycle);
					mismatchCount++;
				end
			end
			// reads see the registers as they were before this edge's write
			if (issueValid)
			begin
				next = refModel(shadow[uop.rm], shadow[uop.ri], uop, wide);
				next.testId = testId;
				next.issueCycle = cycle;
				expQ.push_back(next);
			end
			if (wrEn)
				shadow[wrIdx] = wrData;
		end
		pendingCount = expQ.size();
	end

endmodule

`default_nettype wire

// File: design/aguPipe.sv
/* Three-stage address pipeline, fixed 3-cycle latency, no stall.
   The register file is loaded only through the write strobe. */
`timescale 1ns/10ps
`default_nettype none

`include "aguPipe_cfg.svh"

module aguPipe (
	input wire logic clk,
	input wire logic rst,
	input wire logic issueValid,
	input aguPipePkg::aguUop_t uop,
	input wire logic wide,
	input wire logic wrEn,
	input wire logic [`AGU_REG_IDX_W-1:0] wrIdx,
	input wire logic [`AGU_ADDR_W-1:0] wrData,
	output logic outValid,
	output logic [`AGU_ADDR_W-1:0] outAddr,
	output aguPipePkg::fault_t outFault
);

	import aguPipePkg::*;

	// register file read path
	logic [`AGU_REG_IDX_W-1:0] rdIdxA;
	logic [`AGU_REG_IDX_W-1:0] rdIdxB;
	logic [`AGU_ADDR_W-1:0] rdDataA;
	logic [`AGU_ADDR_W-1:0] rdDataB;

	// stage handoffs
	logic opValid;
	aguOperands_t ops;
	logic resValid;
	aguResult_t res;

	aguRegFile aguRegFile_inst (.clk(clk), .rst(rst), .rdIdxA(rdIdxA), .rdIdxB(rdIdxB),
		.rdDataA(rdDataA), .rdDataB(rdDataB), .wrEn(wrEn), .wrIdx(wrIdx), .wrData(wrData));

	// stage 1
	aguIssueStage aguIssueStage_inst (.clk(clk), .rst(rst), .issueValid(issueValid),
		.uop(uop), .wide(wide), .rdIdxA(rdIdxA), .rdIdxB(rdIdxB), .rdDataA(rdDataA),
		.rdDataB(rdDataB), .opValid(opValid), .ops(ops));

	// stage 2
	aguAddrGen aguAddrGen_inst (.clk(clk), .rst(rst), .opValid(opValid), .ops(ops),
		.resValid(resValid), .res(res));

	// stage 3
	aguAccessCheck aguAccessCheck_inst (.clk(clk), .rst(rst), .resValid(resValid),
		.res(res), .outValid(outValid), .outAddr(outAddr), .outFault(outFault));

endmodule

`default_nettype wire

// File: design/aguAccessCheck.sv
/* Stage 3: limit and alignment check. A limit fault hides any alignment
   fault on the same access. */
`timescale 1ns/10ps
`default_nettype none

`include "aguPipe_cfg.svh"

module aguAccessCheck (
	input wire logic clk,
	input wire logic rst,
	input wire logic resValid,
	input aguPipePkg::aguResult_t res,
	output logic outValid,
	output logic [`AGU_ADDR_W-1:0] outAddr,
	output aguPipePkg::fault_t outFault
);

	import aguPipePkg::*;

	logic misaligned;
	fault_t faultNext;

	always_comb
	begin
		// low log2(size) bits must be clear
		case (res.size)
			SIZE_BYTE: misaligned = 1'b0;
			SIZE_WORD: misaligned = res.addr[0];
			SIZE_LONG: misaligned = |res.addr[1:0];
			SIZE_QUAD: misaligned = |res.addr[2:0];
			default: misaligned = 1'b0;
		endcase

		if (res.addr > `AGU_LIMIT)
			faultNext = FAULT_LIMIT;
		else if (misaligned)
			faultNext = FAULT_ALIGN;
		else
			faultNext = FAULT_NONE;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			outValid <= 1'b0;
		else
			outValid <= resValid;
	end

	// address and fault ride alongside the valid
	always_ff @(posedge clk)
	begin
		outAddr <= res.addr;
		outFault <= faultNext;
	end

endmodule

`default_nettype wire

// File: design/aguAddrGen.sv
/* Stage 2: base + (index << scale) + disp over three carry-select segments.
   Index is extended from its low 32 bits; narrow mode zeroes the top segment. */
`timescale 1ns/10ps
`default_nettype none

`include "aguPipe_cfg.svh"

module aguAddrGen (
	input wire logic clk,
	input wire logic rst,
	input wire logic opValid,
	input aguPipePkg::aguOperands_t ops,
	output logic resValid,
	output aguPipePkg::aguResult_t res
);

	import aguPipePkg::*;

	localparam int SegW = `AGU_SEG_W;
	localparam int AddrW = `AGU_ADDR_W;

	// extended and scaled index
	logic [AddrW-1:0] extIdx;
	logic [AddrW-1:0] scIdx;

	// displacement term, zero when disabled
	logic [SegW-1:0] dispTerm;

	// segment sums, two carry bits on top
	logic [SegW+1:0] lowSum;
	logic [SegW+1:0] midSum;
	logic [SegW+1:0] highSum;
	logic [SegW-1:0] highSeg;

	aguResult_t resNext;

	// one carry-select segment
	// carry-in of 0..2: bit 1 folds into both sums, bit 0 picks one
	function automatic logic [SegW+1:0] segSum(
		input logic [SegW-1:0] a,
		input logic [SegW-1:0] b,
		input logic [1:0] cin
	);
		logic [SegW+1:0] sumC0;
		logic [SegW+1:0] sumC1;
		sumC0 = {2'b00, a} + {2'b00, b} + {{SegW{1'b0}}, cin[1], 1'b0};
		sumC1 = sumC0 + 1'b1;
		return cin[0] ? sumC1 : sumC0;
	endfunction

	always_comb
	begin
		// sign-extend from bit 31 unless zext
		extIdx = {(ops.dec.zext ? 16'h0000 : {16{ops.index[31]}}), ops.index[31:0]};

		case (ops.dec.scale)
			SCALE_1: scIdx = extIdx;
			SCALE_2: scIdx = {extIdx[AddrW-2:0], 1'b0};
			SCALE_4: scIdx = {extIdx[AddrW-3:0], 2'b00};
			SCALE_8: scIdx = {extIdx[AddrW-4:0], 3'b000};
			default: scIdx = extIdx;
		endcase

		dispTerm = ops.dec.dispEn ? ops.dec.disp : '0;

		// low segment, three terms so the carry can reach 2
		lowSum = {2'b00, ops.base[SegW-1:0]} + {2'b00, scIdx[SegW-1:0]} + {2'b00, dispTerm};

		// middle takes the full two-bit carry
		midSum = segSum(ops.base[2*SegW-1:SegW], scIdx[2*SegW-1:SegW], lowSum[SegW+1:SegW]);

		// high segment, carry out dropped
		highSum = segSum(ops.base[3*SegW-1:2*SegW], scIdx[3*SegW-1:2*SegW],
			midSum[SegW+1:SegW]);

		// narrow mode
		highSeg = ops.dec.wide ? highSum[SegW-1:0] : '0;

		resNext.addr = {highSeg, midSum[SegW-1:0], lowSum[SegW-1:0]};
		resNext.size = ops.dec.size;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			resValid <= 1'b0;
		else
			resValid <= opValid;
	end

	always_ff @(posedge clk)
	begin
		res <= resNext;
	end

endmodule

`default_nettype wire

// File: design/aguIssueStage.sv
/* Stage 1: decodes the control word and launches the register reads.
   Condition code bits are ignored, every issue proceeds. */
`timescale 1ns/10ps
`default_nettype none

`include "aguPipe_cfg.svh"

module aguIssueStage (
	input wire logic clk,
	input wire logic rst,
	input wire logic issueValid,
	input aguPipePkg::aguUop_t uop,
	input wire logic wide,
	output logic [`AGU_REG_IDX_W-1:0] rdIdxA,
	output logic [`AGU_REG_IDX_W-1:0] rdIdxB,
	input wire logic [`AGU_ADDR_W-1:0] rdDataA,
	input wire logic [`AGU_ADDR_W-1:0] rdDataB,
	output logic opValid,
	output aguPipePkg::aguOperands_t ops
);

	import aguPipePkg::*;

	// decoded fields, combinational and registered
	aguDecoded_t decNext;
	aguDecoded_t decReg;

	// register indices go straight to the register file
	assign rdIdxA = uop.rm;
	assign rdIdxB = uop.ri;

	// split the control word
	always_comb
	begin
		decNext.size = accSize_t'(uop.ctrl[5:4]);
		decNext.scale = scale_t'(uop.ctrl[1:0]);
		decNext.zext = uop.ctrl[2];
		decNext.dispEn = uop.ctrl[3];
		decNext.wide = wide;
		decNext.disp = uop.disp;
	end

	// valid tracks the register read latency
	always_ff @(posedge clk)
	begin
		if (rst)
			opValid <= 1'b0;
		else
			opValid <= issueValid;
	end

	always_ff @(posedge clk)
	begin
		decReg <= decNext;
	end

	// decoded fields and read data both arrive one cycle after issue
	always_comb
	begin
		ops.dec = decReg;
		ops.base = rdDataA;
		ops.index = rdDataB;
	end

endmodule

`default_nettype wire

// File: design/aguRegFile.sv
/* Register file with two registered read ports and one write port.
   Same-cycle read and write of one entry returns the old contents. */
`timescale 1ns/10ps
`default_nettype none

`include "aguPipe_cfg.svh"

module aguRegFile (
	input wire logic clk,
	input wire logic rst,
	input wire logic [`AGU_REG_IDX_W-1:0] rdIdxA,
	input wire logic [`AGU_REG_IDX_W-1:0] rdIdxB,
	output logic [`AGU_ADDR_W-1:0] rdDataA,
	output logic [`AGU_ADDR_W-1:0] rdDataB,
	input wire logic wrEn,
	input wire logic [`AGU_REG_IDX_W-1:0] wrIdx,
	input wire logic [`AGU_ADDR_W-1:0] wrData
);

	// register array
	logic [`AGU_ADDR_W-1:0] regs [`AGU_REG_CNT];

	// write port, whole array cleared on reset
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `AGU_REG_CNT; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wrEn)
		begin
			regs[wrIdx] <= wrData;
		end
	end

	// read ports, data one cycle after the index
	// nonblocking read sees the value before this edge's write
	always_ff @(posedge clk)
	begin
		rdDataA <= regs[rdIdxA];
		rdDataB <= regs[rdIdxB];
	end

endmodule

`default_nettype wire

// File: design/aguPipePkg.sv
/* Shared types of the address pipeline. Control word bits [7:6] (condition
   code) and bit 8 are carried in the micro-op but never decoded. */
`default_nettype none

`include "aguPipe_cfg.svh"

package aguPipePkg;

	// access size, ctrl[5:4]
	typedef enum logic [1:0] {SIZE_BYTE, SIZE_WORD, SIZE_LONG, SIZE_QUAD} accSize_t;

	// index shift amount, ctrl[1:0]
	typedef enum logic [1:0] {SCALE_1, SCALE_2, SCALE_4, SCALE_8} scale_t;

	// fault code on the output, limit wins over alignment
	typedef enum logic [1:0] {FAULT_NONE, FAULT_ALIGN, FAULT_LIMIT} fault_t;

	// issue payload
	typedef struct packed {
		logic [`AGU_REG_IDX_W-1:0] rm;
		logic [`AGU_REG_IDX_W-1:0] ri;
		logic [15:0] disp;
		logic [8:0] ctrl;
	} aguUop_t;

	// control word after decode, held in stage 1
	typedef struct packed {
		accSize_t size;
		scale_t scale;
		logic zext;
		logic dispEn;
		logic wide;
		logic [15:0] disp;
	} aguDecoded_t;

	// stage 2 input, decoded fields lined up with the register data
	typedef struct packed {
		aguDecoded_t dec;
		logic [`AGU_ADDR_W-1:0] base;
		logic [`AGU_ADDR_W-1:0] index;
	} aguOperands_t;

	// stage 2 output
	typedef struct packed {
		logic [`AGU_ADDR_W-1:0] addr;
		accSize_t size;
	} aguResult_t;

endpackage

`default_nettype wire

// File: design/aguPipe_cfg.svh
/* Address pipeline configuration. The segment width must divide the
   address width into exactly three segments for the carry-select adder. */
`ifndef AGU_PIPE_CFG_SVH
`define AGU_PIPE_CFG_SVH

// full effective address width
`define AGU_ADDR_W 48

// carry-select adder segment width
`define AGU_SEG_W 16

// register file depth and index width
`define AGU_REG_CNT 16
`define AGU_REG_IDX_W 4

// highest address an access may reach without a limit fault
`define AGU_LIMIT 48'h0000_FFFF_FFFF

`endif
